// File: include/lane_sync_defs.svh
`ifndef LANE_SYNC_DEFS_SVH
`define LANE_SYNC_DEFS_SVH

// deserialization factor, bits per lane word
`define LS_WORD_W           8

// strobe training words, pattern word 2 sits above word 1
`define LS_PAT1             8'hff
`define LS_PAT2             8'h00

// largest skew corrected in either direction
`define LS_MAX_SHIFT        7

`define LS_WINDOW_WORDS     4   // history depth in words

// edges spent in SETTLE before matches count
`define LS_SETTLE_CYCLES    3

`endif

// File: hdl/lane_sync_pkg.sv
`include "lane_sync_defs.svh"

package lane_sync_pkg;

    ////////////////////
    // vector types

    typedef logic [`LS_WORD_W-1:0]                  lane_word_t;
    typedef logic [`LS_WORD_W*`LS_WINDOW_WORDS-1:0] lane_window_t;  // newest word on top
    typedef logic [2*`LS_WORD_W-1:0]                strobe_pat_t;
    typedef logic signed [3:0]                      lane_offset_t;  // positive is a right shift

    ////////////////////
    // bundles

    typedef struct packed {
        lane_window_t data;
        lane_window_t strobe;
    } lane_hist_t;

    typedef struct packed {
        logic         found;
        lane_offset_t offset;
    } shift_match_t;

    // calibration sequence
    typedef enum logic [2:0] {
        IDLE,
        SETTLE,
        SEARCH,
        LOAD,
        LOCKED
    } align_state_t;

endpackage

// File: hdl/lane_pattern_search.sv
`timescale 1ns/1ps
`include "lane_sync_defs.svh"

module lane_pattern_search
(
    input  logic                        clk,
    input  logic                        rst_in,
    input  lane_sync_pkg::lane_word_t   raw_data_i,
    input  lane_sync_pkg::lane_word_t   raw_strobe_i,
    output lane_sync_pkg::lane_hist_t   hist_o,
    output lane_sync_pkg::shift_match_t match_o
);

    import lane_sync_pkg::*;

    localparam int W       = `LS_WORD_W;
    localparam int TOP_BIT = 3*W - 1;        // top of the centre field, bit 23
    localparam strobe_pat_t PATTERN = {`LS_PAT2, `LS_PAT1};

    lane_hist_t   hist_q;
    shift_match_t match_d;
    shift_match_t match_q;
    logic         strobe_ok;
    logic [2*`LS_MAX_SHIFT:0] hit;           // index is offset + max shift

    ////////////////////
    // history window

    always_ff @(posedge clk or posedge rst_in)
    begin
        if (rst_in)
        begin
            hist_q <= '0;
        end
        else
        begin
            // newest word enters at the top, oldest drops out of the bottom byte
            hist_q.data   <= {raw_data_i, hist_q.data[4*W-1:W]};
            hist_q.strobe <= {raw_strobe_i, hist_q.strobe[4*W-1:W]};
        end
    end

    ////////////////////
    // pattern compare

    // the strobe lane must show the pattern unshifted
    assign strobe_ok = (hist_q.strobe[TOP_BIT -: 2*W] == PATTERN);

    for (genvar g = 0; g <= 2*`LS_MAX_SHIFT; g++)
    begin : g_cmp
        assign hit[g] = (hist_q.data[TOP_BIT + g - `LS_MAX_SHIFT -: 2*W] == PATTERN);
    end

    // priority 0, -1 .. -7, then +1 .. +7
    always_comb
    begin
        match_d = '0;
        if (strobe_ok)
        begin
            for (int k = 0; k <= `LS_MAX_SHIFT; k++)
            begin
                if (!match_d.found && hit[`LS_MAX_SHIFT - k])
                begin
                    match_d.found  = 1'b1;
                    match_d.offset = lane_offset_t'(-k);
                end
            end
            for (int k = 1; k <= `LS_MAX_SHIFT; k++)
            begin
                if (!match_d.found && hit[`LS_MAX_SHIFT + k])
                begin
                    match_d.found  = 1'b1;
                    match_d.offset = lane_offset_t'(k);
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst_in)
    begin
        if (rst_in)
            match_q <= '0;
        else
            match_q <= match_d;             // one edge behind the window
    end

    assign hist_o  = hist_q;
    assign match_o = match_q;

    // a reported offset always lies inside the correctable range
    a_offset_range: assert property (@(posedge clk) disable iff (rst_in)
        match_q.found |-> (match_q.offset <= `LS_MAX_SHIFT &&
                           match_q.offset >= -`LS_MAX_SHIFT));

endmodule

// File: hdl/lane_align_ctrl.sv
`timescale 1ns/1ps
`include "lane_sync_defs.svh"

module lane_align_ctrl
(
    input  logic                        clk,
    input  logic                        rst_in,
    input  logic                        start_lane_align_i,
    input  lane_sync_pkg::shift_match_t match_i,
    output lane_sync_pkg::shift_match_t shift_o,
    output logic                        lock_o
);

    import lane_sync_pkg::*;

    localparam int CNT_W = $clog2(`LS_SETTLE_CYCLES + 1);

    align_state_t     state_q;
    align_state_t     state_d;
    logic             start_q;
    logic             start_rise;
    logic [CNT_W-1:0] settle_cnt_q;
    logic             settle_done;
    shift_match_t     shift_q;
    logic             lock_q;

    ////////////////////
    // start edge

    always_ff @(posedge clk or posedge rst_in)
    begin
        if (rst_in)
            start_q <= 1'b0;
        else
            start_q <= start_lane_align_i;
    end

    assign start_rise = start_lane_align_i & ~start_q;

    ////////////////////
    // calibration FSM

    assign settle_done = (settle_cnt_q == CNT_W'(`LS_SETTLE_CYCLES - 1));

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                state_d = IDLE;                 // only a start edge leaves here
            SETTLE:
            begin
                if (settle_done)
                    state_d = SEARCH;           // window refilled, stale hits flushed
            end
            SEARCH:
            begin
                if (match_i.found)
                    state_d = LOAD;
            end
            LOAD:
                state_d = LOCKED;
            LOCKED:
                state_d = LOCKED;
            default:
                state_d = IDLE;
        endcase

        // a new start edge restarts the sequence from any state
        if (start_rise)
            state_d = SETTLE;
    end

    always_ff @(posedge clk or posedge rst_in)
    begin
        if (rst_in)
        begin
            state_q      <= IDLE;
            settle_cnt_q <= '0;
            lock_q       <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            lock_q  <= (state_d == LOCKED);     // drops on the start edge itself

            if (start_rise)
                settle_cnt_q <= '0;
            else if (state_q == SETTLE)
                settle_cnt_q <= settle_cnt_q + 1'b1;
        end
    end

    ////////////////////
    // offset capture

    always_ff @(posedge clk or posedge rst_in)
    begin
        if (rst_in)
            shift_q <= '0;
        else if (state_q == SEARCH && match_i.found && !start_rise)
            shift_q <= match_i;                 // first hit wins, held until next search
    end

    assign shift_o = shift_q;
    assign lock_o  = lock_q;

    // lock is only reached through LOAD
    a_lock_state: assert property (@(posedge clk) disable iff (rst_in)
        $rose(lock_q) |-> $past(state_q) == LOAD);

    // the mux never sees the offset move under a lock
    a_shift_hold: assert property (@(posedge clk) disable iff (rst_in)
        lock_q && $past(lock_q) |-> $stable(shift_q));

endmodule

// File: hdl/lane_shift_mux.sv
`timescale 1ns/1ps
`include "lane_sync_defs.svh"

module lane_shift_mux
(
    input  logic                        clk,
    input  logic                        rst_in,
    input  lane_sync_pkg::lane_hist_t   hist_i,
    input  lane_sync_pkg::shift_match_t shift_i,
    input  logic                        lock_i,
    output lane_sync_pkg::lane_word_t   lane_data_o,
    output lane_sync_pkg::lane_word_t   lane_strobe_o,
    output logic                        data_valid_o
);

    import lane_sync_pkg::*;

    localparam int W       = `LS_WORD_W;
    localparam int MID_TOP = 2*W - 1;       // top bit of the unshifted word

    lane_word_t aligned;
    lane_word_t strobe_word;
    logic       load_en;
    lane_word_t data_q;
    lane_word_t strobe_q;
    logic       valid_q;

    ////////////////////
    // slice select

    // word top bit sits at 15 + offset
    assign aligned     = hist_i.data[MID_TOP + int'(shift_i.offset) -: W];
    assign strobe_word = hist_i.strobe[MID_TOP -: W];

    assign load_en = lock_i & shift_i.found;

    ////////////////////
    // output registers

    always_ff @(posedge clk or posedge rst_in)
    begin
        if (rst_in)
        begin
            data_q   <= '0;
            strobe_q <= '0;
            valid_q  <= 1'b0;
        end
        else if (load_en)
        begin
            data_q   <= aligned;
            strobe_q <= strobe_word;
            valid_q  <= 1'b1;
        end
        else
        begin
            // unlocked, outputs held at zero
            data_q   <= '0;
            strobe_q <= '0;
            valid_q  <= 1'b0;
        end
    end

    assign lane_data_o   = data_q;
    assign lane_strobe_o = strobe_q;
    assign data_valid_o  = valid_q;

    a_zero_idle: assert property (@(posedge clk) disable iff (rst_in)
        !data_valid_o |-> (lane_data_o == '0 && lane_strobe_o == '0));

endmodule

// File: hdl/lane_sync.sv
`timescale 1ns/1ps

module lane_sync
(
    input  logic                      clk,
    input  logic                      rst_in,
    input  logic                      start_lane_align_i,
    input  lane_sync_pkg::lane_word_t raw_data_i,
    input  lane_sync_pkg::lane_word_t raw_strobe_i,
    output lane_sync_pkg::lane_word_t lane_data_o,
    output lane_sync_pkg::lane_word_t lane_strobe_o,
    output logic                      data_valid_o
);

    import lane_sync_pkg::*;

    lane_hist_t   hist;      // both lane windows
    shift_match_t match;     // raw search result
    shift_match_t shift;     // latched offset
    logic         lock;

    lane_pattern_search i_search
    (
        .clk          (clk),
        .rst_in       (rst_in),
        .raw_data_i   (raw_data_i),
        .raw_strobe_i (raw_strobe_i),
        .hist_o       (hist),
        .match_o      (match)
    );

    lane_align_ctrl i_ctrl
    (
        .clk                (clk),
        .rst_in             (rst_in),
        .start_lane_align_i (start_lane_align_i),
        .match_i            (match),
        .shift_o            (shift),
        .lock_o             (lock)
    );

    lane_shift_mux i_mux
    (
        .clk           (clk),
        .rst_in        (rst_in),
        .hist_i        (hist),
        .shift_i       (shift),
        .lock_i        (lock),
        .lane_data_o   (lane_data_o),
        .lane_strobe_o (lane_strobe_o),
        .data_valid_o  (data_valid_o)
    );

endmodule

// File: verif/tb_lane_sync.sv
`timescale 1ns/1ps
`include "lane_sync_defs.svh"

module tb_lane_sync;

    import lane_sync_pkg::*;

    localparam int W            = `LS_WORD_W;
    localparam int MAXS         = `LS_MAX_SHIFT;
    localparam int NUM_FORCED   = 3;            // skews 0, -max, +max
    localparam int NUM_RANDOM   = 12;
    localparam int NUM_ROUNDS   = NUM_FORCED + NUM_RANDOM;
    localparam int ROUND_CYCLES = 200;
    localparam int MAX_CYCLES   = NUM_ROUNDS * ROUND_CYCLES;
    localparam int LOCK_LIMIT   = 32;           // edges from start to valid
    localparam int PAYLOAD_LEN  = 40;

    logic       clk;
    logic       rst_in;
    logic       start_lane_align_i;
    lane_word_t raw_data_i;
    lane_word_t raw_strobe_i;
    lane_word_t lane_data_o;
    lane_word_t lane_strobe_o;
    logic       data_valid_o;

    logic [31:0]  lcg_state = 32'd92;
    int           cycle_cnt = 0;
    int           errors    = 0;
    int           bit_time  = 64;               // serial position of the next word
    int           cur_skew  = 0;
    logic         payload_mode = 1'b0;
    bit           ideal_q[$];                   // front is bit time minus max skew
    lane_hist_t   win_cur  = '0;
    lane_hist_t   win_prev = '0;
    lane_word_t   drv_data   = '0;
    lane_word_t   drv_strobe = '0;
    lane_offset_t exp_off  = '0;
    lane_offset_t next_off = '0;

    lane_sync i_dut
    (
        .clk                (clk),
        .rst_in             (rst_in),
        .start_lane_align_i (start_lane_align_i),
        .raw_data_i         (raw_data_i),
        .raw_strobe_i       (raw_strobe_i),
        .lane_data_o        (lane_data_o),
        .lane_strobe_o      (lane_strobe_o),
        .data_valid_o       (data_valid_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    ////////////////////
    // failure reporting

    task automatic fail_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fail_check(input string msg);
        fail_run($sformatf("ERR %0t: %s", $time, msg));
    endtask

    initial
    begin : watchdog
        wait (cycle_cnt > MAX_CYCLES);
        fail_run($sformatf("timeout, the run did not finish within %0d cycles", MAX_CYCLES));
    end

    ////////////////////
    // serial source model

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // strobe alternates pattern words, even word index sends word 1
    function automatic lane_word_t train_word(input int word_idx);
        return (word_idx % 2 == 0) ? lane_word_t'(`LS_PAT1) : lane_word_t'(`LS_PAT2);
    endfunction

    function automatic bit gen_bit(input int idx);
        logic [31:0] r;
        lane_word_t  tw;
        if (payload_mode)
        begin
            r = lcg_next();
            return r[16];
        end
        tw = train_word(idx / W);
        return tw[idx % W];
    endfunction

    // first hit in the order 0, -1 .. -max, +1 .. +max
    function automatic shift_match_t find_match(input lane_window_t dwin,
                                                input lane_window_t swin);
        shift_match_t m;
        strobe_pat_t  pat;
        int           off;
        pat = {`LS_PAT2, `LS_PAT1};
        m   = '0;
        if (swin[23:8] == pat)
        begin
            for (int k = 0; k <= 2*MAXS; k++)
            begin
                off = (k <= MAXS) ? -k : k - MAXS;
                if (!m.found && strobe_pat_t'(dwin >> (8 + off)) == pat)
                begin
                    m.found  = 1'b1;
                    m.offset = lane_offset_t'(off);
                end
            end
        end
        return m;
    endfunction

    task automatic make_words(output lane_word_t d_w, output lane_word_t s_w);
        s_w = train_word(bit_time / W);
        while (ideal_q.size() < 2*MAXS + W)
            ideal_q.push_back(gen_bit(bit_time - MAXS + ideal_q.size()));
        for (int j = 0; j < W; j++)
            d_w[j] = ideal_q[j + MAXS - cur_skew];  // data lags by the skew
        repeat (W) void'(ideal_q.pop_front());
        bit_time += W;
    endtask

    ////////////////////
    // one clock: model update, output check, new inputs

    task automatic step(input logic start_val);
        lane_word_t d_w;
        lane_word_t s_w;
        lane_word_t exp_d;
        @(negedge clk);
        win_prev        = win_cur;
        win_cur.data    = {drv_data, win_cur.data[4*W-1:W]};
        win_cur.strobe  = {drv_strobe, win_cur.strobe[4*W-1:W]};

        if (data_valid_o)
        begin
            exp_d = lane_word_t'(win_prev.data >> (8 + int'(exp_off)));
            assert (lane_data_o == exp_d)
            else fail_check($sformatf("lane_data_o %h, expected %h at offset %0d",
                                      lane_data_o, exp_d, exp_off));
            assert (lane_strobe_o == win_prev.strobe[15:8])
            else fail_check($sformatf("lane_strobe_o %h, expected %h",
                                      lane_strobe_o, win_prev.strobe[15:8]));
        end
        else
        begin
            exp_off = next_off;             // new offset applies once valid is low
            assert (lane_data_o == '0 && lane_strobe_o == '0)
            else fail_check($sformatf("outputs %h/%h not zero while invalid",
                                      lane_data_o, lane_strobe_o));
        end

        make_words(d_w, s_w);
        raw_data_i         = d_w;
        raw_strobe_i       = s_w;
        start_lane_align_i = start_val;
        drv_data           = d_w;
        drv_strobe         = s_w;
    endtask

    task automatic run_round(input int skew);
        shift_match_t m;
        int           waited;
        payload_mode = 1'b0;
        cur_skew     = skew;
        repeat (8) step(1'b0);              // refill the window with training
        m = find_match(win_cur.data, win_cur.strobe);
        assert (m.found && int'(m.offset) == skew)
        else fail_run($sformatf("model window shows no pattern at skew %0d", skew));
        next_off = m.offset;

        step(1'b1);
        step(1'b0);
        step(1'b0);
        assert (!data_valid_o)
        else fail_check("data_valid_o still high two edges after start");

        waited = 0;
        while (!data_valid_o)
        begin
            step(1'b0);
            waited++;
            assert (waited < LOCK_LIMIT)
            else fail_run($sformatf("no lock for skew %0d after %0d cycles", skew, waited));
        end

        payload_mode = 1'b1;
        repeat (PAYLOAD_LEN)
        begin
            step(1'b0);
            assert (data_valid_o)
            else fail_check($sformatf("data_valid_o dropped in payload, skew %0d", skew));
        end
    endtask

    ////////////////////
    // main sequence

    initial
    begin : stimulus
        int          skew;
        int          prev_skew;
        logic [31:0] r;
        rst_in             = 1'b1;
        start_lane_align_i = 1'b0;
        raw_data_i         = '0;
        raw_strobe_i       = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_in = 1'b0;

        repeat (4)
        begin
            step(1'b0);
            assert (!data_valid_o)
            else fail_check("data_valid_o high before any start");
        end

        prev_skew = 2*MAXS + 1;
        for (int n = 0; n < NUM_ROUNDS; n++)
        begin
            if (n == 0)
                skew = 0;
            else if (n == 1)
                skew = -MAXS;
            else if (n == 2)
                skew = MAXS;
            else
            begin
                skew = prev_skew;
                while (skew == prev_skew)   // every round moves the offset
                begin
                    r    = lcg_next();
                    skew = int'(r[23:16] % 8'd15) - MAXS;
                end
            end
            run_round(skew);
            prev_skew = skew;
        end

        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
hdl/lane_sync_pkg.sv
hdl/lane_pattern_search.sv
hdl/lane_align_ctrl.sv
hdl/lane_shift_mux.sv
hdl/lane_sync.sv
verif/tb_lane_sync.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_lane_sync -o tb_lane_sync \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_lane_sync > sim.log 2>&1
cat sim.log
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
